/* cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath byte width
`define CPU_DATA_W 8

// Memory address width, one byte per address
`define CPU_ADDR_W 8

// General registers R0..R3
`define CPU_NUM_REGS 4

// Bytes of unified program and data memory
`define CPU_MEM_DEPTH 256

`endif

/* cpuIsaPkg.sv */
`include "cpu_settings.svh"

package cpuIsaPkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;                 // One data byte
    typedef logic [`CPU_ADDR_W-1:0] addr_t;                 // Memory address
    typedef logic [$clog2(`CPU_NUM_REGS)-1:0] regIdx_t;     // Register number
    typedef logic [2*`CPU_DATA_W-1:0] instr_t;              // Two fetched bytes

    // Opcode lives in instruction bits 15..12
    typedef enum logic [3:0] {
        LDI = 4'd0,     // Rd <= imm
        LDM = 4'd1,     // Rd <= mem[addr]
        STM = 4'd2,     // mem[addr] <= Rs
        MOV = 4'd3,
        AND = 4'd4,
        OR  = 4'd5,
        NOT = 4'd6,
        ADD = 4'd7,
        SUB = 4'd8,
        LSL = 4'd9,
        LSR = 4'd10,
        INC = 4'd11,
        DEC = 4'd12,
        BRA = 4'd13,
        BNE = 4'd14,    // Taken while Z is clear
        NOP = 4'd15
    } opcode_e;

endpackage

/* cpuCtrlPkg.sv */
package cpuCtrlPkg;

    import cpuIsaPkg::*;

    // Three cycles per instruction
    typedef enum logic [1:0] {
        FETCH_HI = 2'd0,
        FETCH_LO = 2'd1,
        EXEC     = 2'd2
    } step_e;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
    } flags_t;

    // Register write-back source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_IMM = 2'd1,
        WB_MEM = 2'd2
    } wbSrc_e;

    typedef struct packed {
        logic    regWe;
        regIdx_t regWsel;
        regIdx_t rdSelA;
        regIdx_t rdSelB;
        wbSrc_e  wbSrc;
        opcode_e aluOp;
        logic    flagsWe;
        logic    fetchHi;       // IR high byte step
        logic    fetchLo;       // IR low byte step
        logic    memWe;
        logic    branch;        // BRA
        logic    branchIfNz;    // BNE with its condition met
        data_t   operand;       // IR bits 7..0
    } ctrl_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t data;
    } memLoad_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t data;
    } memWrite_t;

    typedef struct packed {
        addr_t  pc;
        flags_t flags;
        logic   instrDone;
    } cpuStatus_t;

endpackage

/* instrDecoder.sv */
`timescale 1ns/1ns

module instrDecoder
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  data_t  rdData,
    input  flags_t flags,
    output ctrl_t  ctrl,
    output logic   instrDone
);

    step_e   step;
    instr_t  ir;
    opcode_e opcode;
    regIdx_t dst;
    regIdx_t src;

    // Sequencer, one step per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            step <= FETCH_HI;
        end else begin
            case (step)
                FETCH_HI: step <= FETCH_LO;
                FETCH_LO: step <= EXEC;
                default:  step <= FETCH_HI;
            endcase
        end
    end

    // Instruction register, filled a byte at a time
    always_ff @(posedge clk) begin
        if (!rst && step == FETCH_HI) begin
            ir[15:8] <= rdData;
        end
        if (!rst && step == FETCH_LO) begin
            ir[7:0] <= rdData;
        end
    end

    assign opcode = opcode_e'(ir[15:12]);
    assign dst    = ir[11:10];
    assign src    = ir[9:8];

    always_comb begin
        ctrl         = '0;
        ctrl.regWsel = dst;
        ctrl.rdSelA  = dst;         // First ALU operand
        ctrl.rdSelB  = src;
        ctrl.wbSrc   = WB_ALU;
        ctrl.aluOp   = opcode;
        ctrl.operand = ir[7:0];
        ctrl.fetchHi = (step == FETCH_HI);
        ctrl.fetchLo = (step == FETCH_LO);

        if (step == EXEC) begin
            case (opcode)
                LDI: begin
                    ctrl.regWe = 1'b1;
                    ctrl.wbSrc = WB_IMM;
                end
                LDM: begin
                    ctrl.regWe = 1'b1;
                    ctrl.wbSrc = WB_MEM;
                end
                STM: begin
                    ctrl.memWe  = 1'b1;
                    ctrl.rdSelA = src;  // Store data rides on port A
                end
                MOV, AND, OR, NOT, ADD, SUB, LSL, LSR, INC, DEC: begin
                    ctrl.regWe   = 1'b1;
                    ctrl.flagsWe = 1'b1;
                end
                BRA: ctrl.branch = 1'b1;
                BNE: ctrl.branchIfNz = ~flags.z;
                default: ;
            endcase
        end
    end

    assign instrDone = (step == EXEC);

endmodule

/* regFile.sv */
`timescale 1ns/1ns

`include "cpu_settings.svh"

module regFile
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  ctrl_t ctrl,
    input  data_t aluResult,
    input  data_t rdData,
    output data_t rdA,
    output data_t rdB
);

    data_t regs [`CPU_NUM_REGS];
    data_t wbData;

    always_comb begin
        case (ctrl.wbSrc)
            WB_IMM:  wbData = ctrl.operand;
            WB_MEM:  wbData = rdData;       // LDM read data
            default: wbData = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWe) begin
            regs[ctrl.regWsel] <= wbData;
        end
    end

    assign rdA = regs[ctrl.rdSelA];
    assign rdB = regs[ctrl.rdSelB];

endmodule

/* aluCore.sv */
`timescale 1ns/1ns

module aluCore
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  ctrl_t  ctrl,
    input  data_t  a,
    input  data_t  b,
    output data_t  result,
    output flags_t flags
);

    logic carry;
    logic carryWe;

    always_comb begin
        carry   = flags.c;
        carryWe = 1'b0;
        case (ctrl.aluOp)
            MOV: result = b;
            AND: result = a & b;
            OR:  result = a | b;
            NOT: result = ~b;
            ADD: begin
                {carry, result} = {1'b0, a} + {1'b0, b};
                carryWe = 1'b1;
            end
            SUB: begin
                {carry, result} = {1'b0, a} - {1'b0, b};
                carry   = ~carry;           // Set when no borrow, a >= b
                carryWe = 1'b1;
            end
            LSL: begin
                carry   = b[7];
                result  = {b[6:0], 1'b0};
                carryWe = 1'b1;
            end
            LSR: begin
                carry   = b[0];
                result  = {1'b0, b[7:1]};
                carryWe = 1'b1;
            end
            INC: result = b + 8'd1;
            DEC: result = b - 8'd1;
            default: result = '0;           // Not an ALU instruction
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (ctrl.flagsWe) begin
            flags.z <= (result == '0);
            flags.n <= result[7];
            if (carryWe) begin
                flags.c <= carry;           // Logic ops keep the old carry
            end
        end
    end

endmodule

/* addrUnit.sv */
`timescale 1ns/1ns

module addrUnit
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  ctrl_t ctrl,
    output addr_t pc,
    output addr_t memAddr
);

    logic fetching;
    logic taken;

    assign fetching = ctrl.fetchHi | ctrl.fetchLo;

    // BNE condition is already resolved by the decoder
    assign taken = ctrl.branch | ctrl.branchIfNz;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (fetching) begin
            pc <= pc + 8'd1;
        end else if (taken) begin
            pc <= addr_t'(ctrl.operand);    // Branch target
        end
    end

    // Instruction bytes at pc, data at the operand address
    assign memAddr = fetching ? pc : addr_t'(ctrl.operand);

endmodule

/* dataMemory.sv */
`timescale 1ns/1ns

`include "cpu_settings.svh"

module dataMemory
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic      clk,
    input  memLoad_t  load,
    input  addr_t     addr,
    input  memWrite_t wr,
    output data_t     rdData
);

    data_t mem [`CPU_MEM_DEPTH];

    // Program load has priority over CPU stores
    always_ff @(posedge clk) begin
        if (load.we) begin
            mem[load.addr] <= load.data;
        end else if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    assign rdData = mem[addr];

endmodule

/* cpuTop.sv */
`timescale 1ns/1ns

module cpuTop
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  memLoad_t   load,
    output memWrite_t  store,
    output cpuStatus_t status
);

    ctrl_t  ctrl;
    data_t  rdData;
    data_t  rdA;
    data_t  rdB;
    data_t  aluResult;
    flags_t flags;
    addr_t  pc;
    addr_t  memAddr;
    logic   instrDone;

    instrDecoder decoder_i (
        .clk(clk), .rst(rst), .rdData(rdData), .flags(flags),
        .ctrl(ctrl), .instrDone(instrDone)
    );

    regFile regs_i (
        .clk(clk), .rst(rst), .ctrl(ctrl), .aluResult(aluResult),
        .rdData(rdData), .rdA(rdA), .rdB(rdB)
    );

    aluCore alu_i (
        .clk(clk), .rst(rst), .ctrl(ctrl), .a(rdA), .b(rdB),
        .result(aluResult), .flags(flags)
    );

    addrUnit addr_i (.clk(clk), .rst(rst), .ctrl(ctrl), .pc(pc), .memAddr(memAddr));

    dataMemory mem_i (
        .clk(clk), .load(load), .addr(memAddr), .wr(store), .rdData(rdData)
    );

    assign store  = '{we: ctrl.memWe, addr: addr_t'(ctrl.operand), data: rdA};
    assign status = '{pc: pc, flags: flags, instrDone: instrDone};

endmodule

/* cpuTb.sv */
`timescale 1ns/1ns

`include "cpu_settings.svh"

module cpuTb
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
();

    bit         clk;
    logic       rst;
    memLoad_t   load;
    memWrite_t  store;
    cpuStatus_t status;

    data_t     image [`CPU_MEM_DEPTH];      // Memory contents at reset
    addr_t     pcBuild;                     // Next free program byte
    integer    seed;
    memWrite_t expStores [$];
    addr_t     expPc [$];                   // pc after each instruction
    flags_t    expFlags [$];
    int        nInstr;
    int        cycleLimit;
    int        cycSinceReset;
    int        doneCount;
    bit        postCheck;
    bit        lastDone;

    cpuTop dut_i (.clk(clk), .rst(rst), .load(load), .store(store), .status(status));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stopRun($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic data_t nextRandom();
        return data_t'($random(seed));
    endfunction

    task automatic placeInstr(input opcode_e op, input regIdx_t d, input regIdx_t s,
                              input data_t imm);
        image[pcBuild]        = {op, d, s};
        image[pcBuild + 8'd1] = imm;
        pcBuild               = pcBuild + 8'd2;
    endtask

    task automatic buildProgram();
        opcode_e aluOps [11];
        data_t   a;
        data_t   b;
        addr_t   loopAddr;

        aluOps = '{ADD, AND, OR, MOV, NOT, SUB, LSL, LSR, INC, DEC, SUB};
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            image[i] = data_t'(i) ^ 8'hA5;      // Filler, never executed
        end
        pcBuild = '0;

        // Random immediates stored to D0..D3
        for (int k = 0; k < 4; k++) begin
            placeInstr(LDI, regIdx_t'(k), 2'd0, nextRandom());
            placeInstr(STM, 2'd0, regIdx_t'(k), data_t'(8'hD0 + k));
        end

        // ADD first so AND has a set carry to keep
        for (int i = 0; i < 11; i++) begin
            a = nextRandom();
            b = nextRandom();
            if (aluOps[i] == ADD) begin
                a = a | 8'h80;                  // Forces a carry out
                b = b | 8'h80;
            end
            placeInstr(LDI, 2'd2, 2'd0, a);
            placeInstr(LDI, 2'd3, 2'd0, b);
            placeInstr(aluOps[i], 2'd2, (i == 10) ? 2'd2 : 2'd3, 8'h00); // Last SUB is zero
            placeInstr(STM, 2'd0, 2'd2, data_t'(8'hE0 + i));
        end

        image[8'hF0] = nextRandom();            // Written only by the load port
        placeInstr(LDM, 2'd1, 2'd0, 8'hF0);
        placeInstr(STM, 2'd0, 2'd1, 8'hF8);
        placeInstr(LDM, 2'd2, 2'd0, 8'hD0);     // Byte from an earlier STM
        placeInstr(STM, 2'd0, 2'd2, 8'hF9);

        // Countdown loop, one store per pass
        placeInstr(LDI, 2'd0, 2'd0, 8'd5);
        loopAddr = pcBuild;
        placeInstr(STM, 2'd0, 2'd0, 8'hFA);
        placeInstr(DEC, 2'd0, 2'd0, 8'h00);
        placeInstr(BNE, 2'd0, 2'd0, loopAddr);

        placeInstr(BRA, 2'd0, 2'd0, pcBuild + 8'd4);
        placeInstr(STM, 2'd0, 2'd1, 8'hFB);     // Skipped by the BRA
        placeInstr(STM, 2'd0, 2'd0, 8'hFC);
        placeInstr(BRA, 2'd0, 2'd0, pcBuild);   // Halt loop
    endtask

    // ISA model, runs until the branch to itself
    function automatic int runModel();
        data_t   r [`CPU_NUM_REGS];
        data_t   mem [`CPU_MEM_DEPTH];
        addr_t   pc;
        addr_t   here;
        flags_t  f;
        instr_t  ir;
        opcode_e op;
        regIdx_t d;
        regIdx_t s;
        data_t   imm;
        data_t   res;
        logic    cNew;
        int      n;
        bit      halted;

        r      = '{default: '0};
        mem    = image;
        pc     = '0;
        f      = '0;
        n      = 0;
        halted = 1'b0;
        while (!halted && n < 500) begin
            here = pc;
            ir   = {mem[pc], mem[pc + 8'd1]};
            pc   = pc + 8'd2;
            op   = opcode_e'(ir[15:12]);
            d    = ir[11:10];
            s    = ir[9:8];
            imm  = ir[7:0];
            res  = '0;
            cNew = f.c;                         // Kept unless the op sets it
            case (op)
                LDI: r[d] = imm;
                LDM: r[d] = mem[imm];
                STM: begin
                    mem[imm] = r[s];
                    expStores.push_back(memWrite_t'{we: 1'b1, addr: imm, data: r[s]});
                end
                BRA: pc = imm;
                BNE: if (!f.z) pc = imm;
                MOV: res = r[s];
                AND: res = r[d] & r[s];
                OR:  res = r[d] | r[s];
                NOT: res = ~r[s];
                ADD: begin
                    res  = r[d] + r[s];
                    cNew = (int'(r[d]) + int'(r[s])) > 255;
                end
                SUB: begin
                    res  = r[d] - r[s];
                    cNew = r[d] >= r[s];
                end
                LSL: begin
                    res  = r[s] << 1;
                    cNew = r[s][7];
                end
                LSR: begin
                    res  = r[s] >> 1;
                    cNew = r[s][0];
                end
                INC: res = r[s] + 8'd1;
                DEC: res = r[s] - 8'd1;
                default: ;
            endcase
            if (op >= MOV && op <= DEC) begin
                r[d] = res;
                f    = '{z: (res == 8'd0), c: cNew, n: res[7]};
            end
            halted = (op == BRA) && (imm == here);
            expPc.push_back(pc);
            expFlags.push_back(f);
            n++;
        end
        return n;
    endfunction

    initial begin
        rst        = 1'b1;
        load       = '0;
        seed       = 32'h2ed4;
        buildProgram();
        nInstr     = runModel();
        cycleLimit = 3 * nInstr + 50;
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            @(negedge clk);
            load.we   = 1'b1;
            load.addr = addr_t'(i);
            load.data = image[i];
        end
        @(negedge clk);
        load.we = 1'b0;
        repeat (10) @(negedge clk);             // Ten reset cycles after the load
        rst = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            cycSinceReset <= 0;
        end else begin
            cycSinceReset <= cycSinceReset + 1;
            if (cycSinceReset >= cycleLimit) begin
                stopRun($sformatf("Timeout: program not finished after %0d cycles", cycleLimit));
            end
        end
    end

    // EXEC is every third cycle counted from the reset release
    always @(negedge clk) begin
        checkEq("status.instrDone", 32'(status.instrDone), 32'(cycSinceReset % 3 == 2));
        if (store.we) begin
            if (cycSinceReset % 3 != 2) begin
                stopRun("store.we was asserted outside an EXEC cycle");
            end else if (expStores.size() == 0) begin
                stopRun("The DUT made a store that the model does not expect");
            end else begin
                checkEq("store.addr", 32'(store.addr), 32'(expStores[0].addr));
                checkEq("store.data", 32'(store.data), 32'(expStores[0].data));
                void'(expStores.pop_front());
            end
        end
        lastDone = 1'b0;
        if (postCheck) begin                    // pc and flags settle after EXEC
            checkEq("status.pc", 32'(status.pc), 32'(expPc[doneCount - 1]));
            checkEq("status.flags", {29'd0, status.flags}, {29'd0, expFlags[doneCount - 1]});
            lastDone = (doneCount == nInstr);
        end
        postCheck = status.instrDone;
        if (status.instrDone) begin
            doneCount++;
        end
        if (lastDone) begin
            if (expStores.size() != 0) begin
                stopRun($sformatf("%0d expected stores never appeared", expStores.size()));
            end else begin
                $display("ALL TESTS PASSED");
                $finish;
            end
        end
    end

endmodule

/* filelist.f */
+incdir+.
cpuIsaPkg.sv
cpuCtrlPkg.sv
instrDecoder.sv
regFile.sv
aluCore.sv
addrUnit.sv
dataMemory.sv
cpuTop.sv
cpuTb.sv

/* Makefile */
TOP = cpuTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --top-module $(TOP) -f filelist.f -o cpuSim
	./obj_dir/cpuSim

clean:
	rm -rf obj_dir
